//--- rv_pkg.sv
package rv_pkg;

  localparam int unsigned xlen = 32;
  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;
  localparam logic [31:0] nop_inst = 32'h0000_0013;  // addi x0, x0, 0

  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam logic [11:0] csr_mstatus = 12'h300;
  localparam logic [11:0] csr_mtvec   = 12'h305;
  localparam logic [11:0] csr_mepc    = 12'h341;
  localparam logic [11:0] csr_mcause  = 12'h342;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } inst_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  typedef enum logic [2:0] {
    br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu
  } br_op_e;

  typedef enum logic [1:0] {wb_alu, wb_pc_plus4, wb_load, wb_csr} wb_sel_e;

  typedef enum logic [2:0] {csr_none, csr_write, csr_set, csr_ecall, csr_mret} csr_op_e;

  typedef enum logic [1:0] {mem_byte, mem_half, mem_word} mem_size_e;

endpackage

//--- rv_dec_if.sv
interface rv_dec_if;
  import rv_pkg::*;

  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [4:0]      rd;
  logic [xlen-1:0] imm;
  alu_op_e         alu_op;
  logic            use_imm;
  logic            use_pc;
  br_op_e          br_op;
  wb_sel_e         wb_sel;
  logic            rf_wen;
  logic            load;
  logic            store;
  mem_size_e       mem_size;
  logic            load_unsigned;
  csr_op_e         csr_op;
  logic [11:0]     csr_addr;
  logic            jal;
  logic            jalr;
  logic            ebreak;

  modport dec (
    output rs1, rs2, rd, imm, alu_op, use_imm, use_pc, br_op, wb_sel, rf_wen,
           load, store, mem_size, load_unsigned, csr_op, csr_addr, jal, jalr, ebreak
  );
  modport exe (input imm, alu_op, use_imm, use_pc, br_op);
  modport csr (input csr_op, csr_addr);
  modport lsu (input load, store, mem_size, load_unsigned);
  modport core (input rs1, rs2, rd, wb_sel, rf_wen, csr_op, jal, jalr, ebreak);

endinterface

//--- rv_decode.sv
module rv_decode (
  input rv_pkg::inst_t inst,
  rv_dec_if.dec        dec
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // Legal funct7 for OP and OP-IMM
  function automatic logic funct7_ok(logic [6:0] opc, logic [2:0] f3, logic [6:0] f7);
    logic is_shift;
    is_shift = (f3 == 3'b001) || (f3 == 3'b101);
    if (opc == op_imm && !is_shift)
      return 1'b1;  // funct7 bits belong to the immediate
    if (f7 == 7'b0000000)
      return 1'b1;
    return (f7 == 7'b0100000) && ((f3 == 3'b101) || (opc == op_reg && f3 == 3'b000));
  endfunction

  assign opcode = inst.r.opcode;
  assign funct3 = inst.r.funct3;
  assign funct7 = inst.r.funct7;

  assign dec.rs1      = inst.r.rs1;
  assign dec.rs2      = inst.r.rs2;
  assign dec.rd       = inst.r.rd;
  assign dec.csr_addr = inst.i.imm_11_0;

  always_comb begin
    dec.imm           = '0;
    dec.alu_op        = alu_add;
    dec.use_imm       = 1'b0;
    dec.use_pc        = 1'b0;
    dec.br_op         = br_none;
    dec.wb_sel        = wb_alu;
    dec.rf_wen        = 1'b0;
    dec.load          = 1'b0;
    dec.store         = 1'b0;
    dec.mem_size      = mem_word;
    dec.load_unsigned = 1'b0;
    dec.csr_op        = csr_none;
    dec.jal           = 1'b0;
    dec.jalr          = 1'b0;
    dec.ebreak        = 1'b0;

    case (opcode)
      op_lui: begin
        dec.imm     = {inst.u.imm_31_12, 12'b0};
        dec.use_imm = 1'b1;
        dec.alu_op  = alu_pass_b;
        dec.rf_wen  = 1'b1;
      end
      op_auipc: begin
        dec.imm     = {inst.u.imm_31_12, 12'b0};
        dec.use_imm = 1'b1;
        dec.use_pc  = 1'b1;
        dec.rf_wen  = 1'b1;
      end
      op_jal: begin
        dec.imm     = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                       inst.j.imm_11, inst.j.imm_10_1, 1'b0};
        dec.use_imm = 1'b1;
        dec.use_pc  = 1'b1;  // ALU forms the target
        dec.wb_sel  = wb_pc_plus4;
        dec.rf_wen  = 1'b1;
        dec.jal     = 1'b1;
      end
      op_jalr: begin
        dec.imm     = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
        dec.use_imm = 1'b1;
        dec.wb_sel  = wb_pc_plus4;
        dec.rf_wen  = (funct3 == 3'b000);
        dec.jalr    = (funct3 == 3'b000);
      end
      op_branch: begin
        dec.imm     = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                       inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
        dec.use_imm = 1'b1;
        dec.use_pc  = 1'b1;
        case (funct3)
          3'b000:  dec.br_op = br_eq;
          3'b001:  dec.br_op = br_ne;
          3'b100:  dec.br_op = br_lt;
          3'b101:  dec.br_op = br_ge;
          3'b110:  dec.br_op = br_ltu;
          3'b111:  dec.br_op = br_geu;
          default: dec.br_op = br_none;
        endcase
      end
      op_load: begin
        dec.imm           = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
        dec.use_imm       = 1'b1;
        dec.wb_sel        = wb_load;
        dec.mem_size      = (funct3[1:0] == 2'b00) ? mem_byte :
                            (funct3[1:0] == 2'b01) ? mem_half : mem_word;
        dec.load_unsigned = funct3[2];
        dec.load          = (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
        dec.rf_wen        = dec.load;
      end
      op_store: begin
        dec.imm      = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
        dec.use_imm  = 1'b1;
        dec.mem_size = (funct3 == 3'b000) ? mem_byte :
                       (funct3 == 3'b001) ? mem_half : mem_word;
        dec.store    = (funct3 inside {3'b000, 3'b001, 3'b010});
      end
      op_imm, op_reg: begin
        dec.use_imm = (opcode == op_imm);
        if (dec.use_imm)
          dec.imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
        case (funct3)
          3'b000:  dec.alu_op = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
          3'b001:  dec.alu_op = alu_sll;
          3'b010:  dec.alu_op = alu_slt;
          3'b011:  dec.alu_op = alu_sltu;
          3'b100:  dec.alu_op = alu_xor;
          3'b101:  dec.alu_op = funct7[5] ? alu_sra : alu_srl;
          3'b110:  dec.alu_op = alu_or;
          default: dec.alu_op = alu_and;
        endcase
        dec.rf_wen = funct7_ok(opcode, funct3, funct7);
      end
      op_system: begin
        if (inst == 32'h0000_0073)
          dec.csr_op = csr_ecall;
        else if (inst == 32'h3020_0073)
          dec.csr_op = csr_mret;
        else if (inst == 32'h0010_0073)
          dec.ebreak = 1'b1;
        else if (funct3 == 3'b001 || funct3 == 3'b010) begin
          dec.csr_op = (funct3 == 3'b001) ? csr_write : csr_set;
          dec.wb_sel = wb_csr;
          dec.rf_wen = 1'b1;
        end
      end
      default: ;  // Unknown opcode retires as a no-op
    endcase
  end

endmodule

//--- rv_alu.sv
module rv_alu (
  rv_dec_if.exe                    dec,
  input  logic [rv_pkg::xlen-1:0] pc,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  input  logic [rv_pkg::xlen-1:0] rs2_data,
  output logic [rv_pkg::xlen-1:0] result,
  output logic                    branch_taken
);
  import rv_pkg::*;

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [4:0]      shamt;
  logic            cmp_eq;
  logic            cmp_lt;
  logic            cmp_ltu;

  assign op_a  = dec.use_pc ? pc : rs1_data;
  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      alu_add:    result = op_a + op_b;
      alu_sub:    result = op_a - op_b;
      alu_sll:    result = op_a << shamt;
      alu_slt:    result = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_sltu:   result = {31'b0, op_a < op_b};
      alu_xor:    result = op_a ^ op_b;
      alu_srl:    result = op_a >> shamt;
      alu_sra:    result = $unsigned($signed(op_a) >>> shamt);
      alu_or:     result = op_a | op_b;
      alu_and:    result = op_a & op_b;
      alu_pass_b: result = op_b;  // lui
      default:    result = '0;
    endcase
  end

  // Branch compare always on register operands
  assign cmp_eq  = (rs1_data == rs2_data);
  assign cmp_lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign cmp_ltu = (rs1_data < rs2_data);

  always_comb begin
    case (dec.br_op)
      br_eq:   branch_taken = cmp_eq;
      br_ne:   branch_taken = !cmp_eq;
      br_lt:   branch_taken = cmp_lt;
      br_ge:   branch_taken = !cmp_lt;
      br_ltu:  branch_taken = cmp_ltu;
      br_geu:  branch_taken = !cmp_ltu;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

//--- rv_regfile.sv
module rv_regfile (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [4:0]              raddr1,
  input  logic [4:0]              raddr2,
  output logic [rv_pkg::xlen-1:0] rdata1,
  output logic [rv_pkg::xlen-1:0] rdata2,
  input  logic                    wen,
  input  logic [4:0]              waddr,
  input  logic [rv_pkg::xlen-1:0] wdata,
  output logic [rv_pkg::xlen-1:0] a0
);
  import rv_pkg::*;

  logic [xlen-1:0] regs [1:31];  // x0 has no storage

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end else if (wen && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];
  assign a0     = regs[10];

endmodule

//--- rv_csr.sv
module rv_csr (
  input  logic                    clk,
  input  logic                    rst_n,
  rv_dec_if.csr                   dec,
  input  logic                    en,
  input  logic [rv_pkg::xlen-1:0] pc,
  input  logic [rv_pkg::xlen-1:0] src,
  input  logic [rv_pkg::xlen-1:0] cause_src,
  output logic [rv_pkg::xlen-1:0] rdata,
  output logic [rv_pkg::xlen-1:0] mepc,
  output logic [rv_pkg::xlen-1:0] mtvec,
  output logic [rv_pkg::xlen-1:0] mcause,
  output logic [rv_pkg::xlen-1:0] mstatus
);
  import rv_pkg::*;

  logic [xlen-1:0] wr_value;
  logic [xlen-1:0] status_trap;
  logic [xlen-1:0] status_ret;

  always_comb begin
    case (dec.csr_addr)
      csr_mstatus: rdata = mstatus;
      csr_mtvec:   rdata = mtvec;
      csr_mepc:    rdata = mepc;
      csr_mcause:  rdata = mcause;
      default:     rdata = '0;
    endcase
  end

  assign wr_value = (dec.csr_op == csr_set) ? (rdata | src) : src;

  // MPP in [12:11], MPIE in 7, MIE in 3
  always_comb begin
    status_trap        = mstatus;
    status_trap[12:11] = 2'b11;
    status_trap[7]     = mstatus[3];
    status_trap[3]     = 1'b0;
  end

  always_comb begin
    status_ret        = mstatus;
    status_ret[12:11] = 2'b00;
    status_ret[7]     = 1'b1;
    status_ret[3]     = mstatus[7];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mepc    <= '0;
      mtvec   <= '0;
      mcause  <= '0;
      mstatus <= '0;
    end else if (en) begin
      case (dec.csr_op)
        csr_write, csr_set: begin
          case (dec.csr_addr)
            csr_mstatus: mstatus <= wr_value;
            csr_mtvec:   mtvec   <= wr_value;
            csr_mepc:    mepc    <= wr_value;
            csr_mcause:  mcause  <= wr_value;
            default: ;  // Unimplemented CSR ignores writes
          endcase
        end
        csr_ecall: begin
          mepc    <= pc;
          mcause  <= cause_src;  // Syscall number from x15
          mstatus <= status_trap;
        end
        csr_mret: mstatus <= status_ret;
        default: ;
      endcase
    end
  end

endmodule

//--- rv_lsu.sv
module rv_lsu (
  rv_dec_if.lsu                   dec,
  input  logic                    en,
  input  logic [rv_pkg::xlen-1:0] addr,
  input  logic [rv_pkg::xlen-1:0] store_data,
  input  logic [rv_pkg::xlen-1:0] dmem_rdata,
  output logic [rv_pkg::xlen-1:0] dmem_addr,
  output logic                    dmem_re,
  output logic                    dmem_we,
  output logic [3:0]              dmem_wstrb,
  output logic [rv_pkg::xlen-1:0] dmem_wdata,
  output logic [rv_pkg::xlen-1:0] load_data
);
  import rv_pkg::*;

  logic [1:0]      offset;
  logic [3:0]      strb;
  logic [xlen-1:0] lane;

  assign offset    = addr[1:0];
  assign dmem_addr = {addr[xlen-1:2], 2'b00};
  assign dmem_re   = en && dec.load;
  assign dmem_we   = en && dec.store;

  always_comb begin
    case (dec.mem_size)
      mem_byte: begin
        strb       = 4'b0001 << offset;
        dmem_wdata = {4{store_data[7:0]}};
      end
      mem_half: begin
        strb       = offset[1] ? 4'b1100 : 4'b0011;
        dmem_wdata = {2{store_data[15:0]}};
      end
      default: begin
        strb       = 4'b1111;
        dmem_wdata = store_data;
      end
    endcase
  end

  assign dmem_wstrb = dmem_we ? strb : 4'b0000;

  assign lane = dmem_rdata >> {offset, 3'b000};  // Addressed byte down to lane 0

  always_comb begin
    case (dec.mem_size)
      mem_byte: load_data = dec.load_unsigned ? {24'b0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
      mem_half: load_data = dec.load_unsigned ? {16'b0, lane[15:0]}
                                              : {{16{lane[15]}}, lane[15:0]};
      default:  load_data = lane;
    endcase
  end

endmodule

//--- rv_core.sv
module rv_core (
  input  logic                    clk,
  input  logic                    rst_n,
  output logic [rv_pkg::xlen-1:0] pc,
  input  logic [rv_pkg::xlen-1:0] inst,
  output logic [rv_pkg::xlen-1:0] dmem_addr,
  output logic                    dmem_re,
  output logic                    dmem_we,
  output logic [3:0]              dmem_wstrb,
  output logic [rv_pkg::xlen-1:0] dmem_wdata,
  input  logic [rv_pkg::xlen-1:0] dmem_rdata,
  output logic                    halt,
  output logic [rv_pkg::xlen-1:0] a0,
  output logic [rv_pkg::xlen-1:0] mepc,
  output logic [rv_pkg::xlen-1:0] mtvec,
  output logic [rv_pkg::xlen-1:0] mcause,
  output logic [rv_pkg::xlen-1:0] mstatus
);
  import rv_pkg::*;

  logic            run;
  logic [4:0]      raddr1;
  logic [xlen-1:0] rf_rdata1;
  logic [xlen-1:0] rf_rdata2;
  logic [xlen-1:0] alu_result;
  logic            branch_taken;
  logic [xlen-1:0] csr_rdata;
  logic [xlen-1:0] load_data;
  logic [xlen-1:0] wb_data;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] next_pc;

  rv_dec_if dec ();

  assign run      = !halt;
  assign pc_plus4 = pc + 32'd4;
  assign raddr1   = (dec.csr_op == csr_ecall) ? 5'd15 : dec.rs1;  // ECALL reads x15

  always_comb begin
    case (dec.wb_sel)
      wb_pc_plus4: wb_data = pc_plus4;
      wb_load:     wb_data = load_data;
      wb_csr:      wb_data = csr_rdata;
      default:     wb_data = alu_result;
    endcase
  end

  always_comb begin
    if (dec.csr_op == csr_mret)
      next_pc = mepc;
    else if (dec.csr_op == csr_ecall)
      next_pc = mtvec;
    else if (dec.jalr)
      next_pc = {alu_result[xlen-1:1], 1'b0};
    else if (dec.jal || branch_taken)
      next_pc = alu_result;  // pc + imm
    else
      next_pc = pc_plus4;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc   <= reset_pc;
      halt <= 1'b0;
    end else if (run) begin
      pc   <= next_pc;
      halt <= dec.ebreak;
    end
  end

  rv_decode u_decode (
    .inst (inst),
    .dec  (dec.dec)
  );

  rv_regfile u_regfile (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr1 (raddr1),
    .raddr2 (dec.rs2),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2),
    .wen    (dec.rf_wen && run),
    .waddr  (dec.rd),
    .wdata  (wb_data),
    .a0     (a0)
  );

  rv_alu u_alu (
    .dec          (dec.exe),
    .pc           (pc),
    .rs1_data     (rf_rdata1),
    .rs2_data     (rf_rdata2),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  rv_csr u_csr (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec       (dec.csr),
    .en        (run),
    .pc        (pc),
    .src       (rf_rdata1),
    .cause_src (rf_rdata1),
    .rdata     (csr_rdata),
    .mepc      (mepc),
    .mtvec     (mtvec),
    .mcause    (mcause),
    .mstatus   (mstatus)
  );

  rv_lsu u_lsu (
    .dec        (dec.lsu),
    .en         (run),
    .addr       (alu_result),
    .store_data (rf_rdata2),
    .dmem_rdata (dmem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_re    (dmem_re),
    .dmem_we    (dmem_we),
    .dmem_wstrb (dmem_wstrb),
    .dmem_wdata (dmem_wdata),
    .load_data  (load_data)
  );

endmodule

//--- tb_rv_core.sv
module tb_rv_core;
  import rv_pkg::*;

  localparam logic [31:0] ecall_inst  = 32'h0000_0073;
  localparam logic [31:0] mret_inst   = 32'h3020_0073;
  localparam logic [31:0] ebreak_inst = 32'h0010_0073;

  logic        clk;
  logic        rst_n;
  logic [31:0] pc, inst, dmem_addr, dmem_wdata, dmem_rdata, a0;
  logic [31:0] mepc, mtvec, mcause, mstatus;
  logic        dmem_re, dmem_we, halt;
  logic [3:0]  dmem_wstrb;

  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];
  logic [31:0] prog [0:511];
  int          nprog;
  string       row_name [0:63];
  int          row_start [0:63];
  int          row_len [0:63];
  int          row_kind [0:63];  // 0 a0, 1 memory word, 2 trap
  logic [31:0] row_exp [0:63];
  int          row_idx [0:63];
  logic [3:0]  row_strb [0:63];
  int          row_pc [0:63];  // Word index of the EBREAK
  int          nrows;
  int          row_begin;
  int          errors;
  int          failed_tests;
  logic [31:0] lcg_state;
  logic        wr_pend;
  logic [7:0]  wr_idx;
  logic [3:0]  wr_strb;
  logic [31:0] wr_data;
  logic [3:0]  last_strb;

  rv_core u_dut (
    .clk (clk), .rst_n (rst_n), .pc (pc), .inst (inst),
    .dmem_addr (dmem_addr), .dmem_re (dmem_re), .dmem_we (dmem_we),
    .dmem_wstrb (dmem_wstrb), .dmem_wdata (dmem_wdata), .dmem_rdata (dmem_rdata),
    .halt (halt), .a0 (a0), .mepc (mepc), .mtvec (mtvec), .mcause (mcause),
    .mstatus (mstatus)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always_comb begin
    logic [31:0] word_idx;
    word_idx = (pc - reset_pc) >> 2;
    inst = (word_idx < 256) ? imem[word_idx[7:0]] : nop_inst;
  end

  assign dmem_rdata = dmem[dmem_addr[9:2]];

  // Request sampled mid-cycle, committed at the edge
  always @(negedge clk) begin
    wr_pend <= dmem_we;
    wr_idx  <= dmem_addr[9:2];
    wr_strb <= dmem_wstrb;
    wr_data <= dmem_wdata;
    if (dmem_we)
      last_strb <= dmem_wstrb;
  end

  always @(posedge clk) begin
    if (wr_pend) begin
      for (int b = 0; b < 4; b++)
        if (wr_strb[b])
          dmem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] r_format(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
    inst_t x;
    x.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: op_reg};
    return x;
  endfunction

  function automatic logic [31:0] i_format(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] op);
    inst_t x;
    x.i = '{imm_11_0: imm, rs1: rs1, funct3: f3, rd: rd, opcode: op};
    return x;
  endfunction

  function automatic logic [31:0] s_format(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
    inst_t x;
    x.s = '{imm_11_5: imm[11:5], rs2: rs2, rs1: rs1, funct3: f3, imm_4_0: imm[4:0],
            opcode: op_store};
    return x;
  endfunction

  function automatic logic [31:0] b_format(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
    inst_t x;
    x.b = '{imm_12: imm[12], imm_10_5: imm[10:5], rs2: rs2, rs1: rs1, funct3: f3,
            imm_4_1: imm[4:1], imm_11: imm[11], opcode: op_branch};
    return x;
  endfunction

  function automatic logic [31:0] u_format(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    inst_t x;
    x.u = '{imm_31_12: imm, rd: rd, opcode: op};
    return x;
  endfunction

  function automatic logic [31:0] j_format(logic [20:0] imm, logic [4:0] rd);
    inst_t x;
    x.j = '{imm_20: imm[20], imm_10_1: imm[10:1], imm_11: imm[11], imm_19_12: imm[19:12],
            rd: rd, opcode: op_jal};
    return x;
  endfunction

  // Reference ALU from the RV32I rules
  function automatic logic [31:0] alu_model(logic [2:0] f3, logic f7_5, logic [31:0] a,
                                            logic [31:0] b);
    case (f3)
      3'd0:    return f7_5 ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return f7_5 ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_model(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  // Jumps, branches, ECALL and MRET may leave pc + 4
  function automatic logic changes_flow(logic [31:0] w);
    return (w[6:0] inside {op_jal, op_jalr, op_branch}) || (w == ecall_inst) ||
           (w == mret_inst);
  endfunction

  task automatic emit(logic [31:0] w);
    prog[nprog] = w;
    nprog++;
  endtask

  task automatic add_row(string n, int kind, logic [31:0] exp, int idx, logic [3:0] strb,
                         int pc_idx);
    row_name[nrows]  = n;
    row_start[nrows] = row_begin;
    row_len[nrows]   = nprog - row_begin;
    row_kind[nrows]  = kind;
    row_exp[nrows]   = exp;
    row_idx[nrows]   = idx;
    row_strb[nrows]  = strb;
    row_pc[nrows]    = pc_idx;
    nrows++;
    row_begin = nprog;
  endtask

  task automatic compare(string sig, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", sig, got, exp);
      errors++;
    end
  endtask

  task automatic run_row(int r);
    int cyc;
    int err_before;
    logic [31:0] held_pc;
    logic [31:0] step_pc;
    logic [31:0] step_inst;
    err_before = errors;
    @(posedge clk);
    #2 rst_n = 1'b0;
    for (int i = 0; i < 256; i++)
      imem[i] = nop_inst;
    for (int i = 0; i < row_len[r]; i++)
      imem[i] = prog[row_start[r] + i];
    repeat (5) @(posedge clk);
    compare("pc", pc, reset_pc);
    compare("halt", {31'b0, halt}, 32'd0);
    compare("mepc", mepc, 32'd0);
    compare("mtvec", mtvec, 32'd0);
    compare("mcause", mcause, 32'd0);
    compare("mstatus", mstatus, 32'd0);
    #2 rst_n = 1'b1;
    cyc = 0;
    @(negedge clk);
    while (!halt && cyc < 200) begin
      step_pc   = pc;
      step_inst = inst;
      @(negedge clk);
      cyc++;
      if (!changes_flow(step_inst))
        compare("pc", pc, step_pc + 32'd4);  // Straight-line step
    end
    if (!halt) begin
      $display("%s: core did not halt within 200 cycles", row_name[r]);
      errors++;
    end
    compare("pc", pc, reset_pc + 4 * (row_pc[r] + 1));  // One past the EBREAK
    case (row_kind[r])
      1: begin
        compare("dmem", dmem[row_idx[r]], row_exp[r]);
        compare("dmem_wstrb", {28'b0, last_strb}, {28'b0, row_strb[r]});
      end
      2: begin
        compare("a0", a0, row_exp[r]);
        compare("mcause", mcause, 32'd93);
        compare("mepc", mepc, reset_pc + 28);  // ECALL pc plus handler's 4
        compare("mtvec", mtvec, reset_pc + 40);
      end
      default: compare("a0", a0, row_exp[r]);
    endcase
    held_pc = pc;
    repeat (10) begin
      @(negedge clk);
      compare("halt", {31'b0, halt}, 32'd1);
      compare("pc", pc, held_pc);
      compare("dmem_we", {31'b0, dmem_we}, 32'd0);
      compare("dmem_re", {31'b0, dmem_re}, 32'd0);
    end
    if (errors == err_before) begin
      $display("%s: ok", row_name[r]);
    end else begin
      $display("%s: failed", row_name[r]);
      failed_tests++;
    end
  endtask

  task automatic build_table();
    logic [2:0]  f3s [0:9];
    logic [31:0] w;
    logic [31:0] st_inst;
    logic [11:0] csrs [0:3];
    f3s = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    for (int k = 0; k < 10; k++) begin
      emit(i_format(12'hff9, 5'd0, 3'd0, 5'd1, op_imm));  // x1 = -7
      emit(i_format(12'h003, 5'd0, 3'd0, 5'd2, op_imm));
      emit(r_format((k == 1 || k == 7) ? 7'h20 : 7'h00, 5'd2, 5'd1, f3s[k], 5'd10));
      emit(ebreak_inst);
      add_row($sformatf("alu_%0d", k), 0,
              alu_model(f3s[k], k == 1 || k == 7, sext12(12'hff9), 32'd3), 0, 4'b0, 3);
    end
    emit(i_format(12'h005, 5'd0, 3'd0, 5'd1, op_imm));
    emit(i_format(12'hffd, 5'd0, 3'd0, 5'd2, op_imm));
    emit(r_format(7'h00, 5'd2, 5'd1, 3'd2, 5'd10));
    emit(ebreak_inst);
    add_row("slt_neg", 0, alu_model(3'd2, 1'b0, 32'd5, sext12(12'hffd)), 0, 4'b0, 3);
    emit(i_format(12'hff9, 5'd0, 3'd0, 5'd1, op_imm));
    emit(i_format(12'h402, 5'd1, 3'd5, 5'd10, op_imm));  // srai x10, x1, 2
    emit(ebreak_inst);
    add_row("srai", 0, alu_model(3'd5, 1'b1, sext12(12'hff9), 32'd2), 0, 4'b0, 2);
    emit(u_format(20'habcde, 5'd10, op_lui));
    emit(ebreak_inst);
    add_row("lui", 0, 32'habcd_e000, 0, 4'b0, 1);
    emit(u_format(20'h12345, 5'd10, op_auipc));
    emit(ebreak_inst);
    add_row("auipc", 0, reset_pc + 32'h1234_5000, 0, 4'b0, 1);
    // Loads from words 0x40..0x42
    for (int k = 0; k < 5; k++) begin
      logic [2:0]  lf3 [0:4];
      logic [11:0] off [0:4];
      logic [31:0] exp [0:4];
      lf3 = '{3'd0, 3'd4, 3'd1, 3'd5, 3'd2};
      off = '{12'h003, 12'h001, 12'h006, 12'h004, 12'h008};
      exp[0] = {{24{dmem[8'h40][31]}}, dmem[8'h40][31:24]};
      exp[1] = {24'b0, dmem[8'h40][15:8]};
      exp[2] = {{16{dmem[8'h41][31]}}, dmem[8'h41][31:16]};
      exp[3] = {16'b0, dmem[8'h41][15:0]};
      exp[4] = dmem[8'h42];
      emit(i_format(12'h100, 5'd0, 3'd0, 5'd1, op_imm));
      emit(i_format(off[k], 5'd1, lf3[k], 5'd10, op_load));
      emit(ebreak_inst);
      emit(i_format(off[k], 5'd1, lf3[k], 5'd10, op_load));  // Presented while halted
      add_row($sformatf("load_%0d", k), 0, exp[k], 0, 4'b0, 2);
    end
    for (int k = 0; k < 3; k++) begin
      emit(i_format(12'h100, 5'd0, 3'd0, 5'd1, op_imm));
      emit(i_format(12'hfab, 5'd0, 3'd0, 5'd2, op_imm));
      st_inst = s_format(k == 0 ? 12'h021 : (k == 1 ? 12'h026 : 12'h028), 5'd2, 5'd1,
                         k[2:0]);
      emit(st_inst);
      emit(ebreak_inst);
      emit(st_inst);  // Presented while halted
      w = dmem[8'h48 + k];
      if (k == 0)
        add_row("sb", 1, {w[31:16], 8'hab, w[7:0]}, 8'h48, 4'b0010, 3);
      else if (k == 1)
        add_row("sh", 1, {16'hffab, w[15:0]}, 8'h49, 4'b1100, 3);
      else
        add_row("sw", 1, 32'hffff_ffab, 8'h4a, 4'b1111, 3);
    end
    for (int k = 0; k < 12; k++) begin
      logic [2:0]  bf3 [0:5];
      logic [11:0] a;
      bf3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      a = (k < 6) ? 12'hff9 : 12'h003;
      emit(i_format(a, 5'd0, 3'd0, 5'd1, op_imm));
      emit(i_format(12'h003, 5'd0, 3'd0, 5'd2, op_imm));
      emit(b_format(13'd12, 5'd2, 5'd1, bf3[k % 6]));
      emit(i_format(12'h001, 5'd0, 3'd0, 5'd10, op_imm));
      emit(ebreak_inst);
      emit(i_format(12'h002, 5'd0, 3'd0, 5'd10, op_imm));
      emit(ebreak_inst);
      if (branch_model(bf3[k % 6], sext12(a), 32'd3))
        add_row($sformatf("branch_%0d", k), 0, 32'd2, 0, 4'b0, 6);
      else
        add_row($sformatf("branch_%0d", k), 0, 32'd1, 0, 4'b0, 4);
    end
    emit(j_format(21'd8, 5'd10));
    emit(ebreak_inst);
    emit(ebreak_inst);
    add_row("jal", 0, reset_pc + 4, 0, 4'b0, 2);
    emit(u_format(20'h0, 5'd1, op_auipc));
    emit(i_format(12'd13, 5'd1, 3'd0, 5'd10, op_jalr));  // Target bit 0 cleared
    emit(ebreak_inst);
    emit(ebreak_inst);
    add_row("jalr", 0, reset_pc + 8, 0, 4'b0, 3);
    csrs = '{csr_mstatus, csr_mtvec, csr_mepc, csr_mcause};
    for (int k = 0; k < 4; k++) begin
      emit(i_format(12'h5a0, 5'd0, 3'd0, 5'd1, op_imm));
      emit(i_format(csrs[k], 5'd1, 3'd1, 5'd0, op_system));
      emit(i_format(12'h00f, 5'd0, 3'd0, 5'd2, op_imm));
      emit(i_format(csrs[k], 5'd2, 3'd2, 5'd0, op_system));
      emit(i_format(csrs[k], 5'd0, 3'd2, 5'd10, op_system));
      emit(ebreak_inst);
      add_row($sformatf("csr_%h", csrs[k]), 0, 32'h5af, 0, 4'b0, 5);
    end
    emit(u_format(20'h0, 5'd1, op_auipc));
    emit(i_format(12'd40, 5'd1, 3'd0, 5'd1, op_imm));  // Handler at word 10
    emit(i_format(csr_mtvec, 5'd1, 3'd1, 5'd0, op_system));
    emit(i_format(12'd8, 5'd0, 3'd0, 5'd3, op_imm));  // MIE set
    emit(i_format(csr_mstatus, 5'd3, 3'd1, 5'd0, op_system));
    emit(i_format(12'd93, 5'd0, 3'd0, 5'd15, op_imm));
    emit(ecall_inst);
    emit(i_format(csr_mstatus, 5'd0, 3'd2, 5'd10, op_system));
    emit(ebreak_inst);
    emit(nop_inst);
    emit(i_format(csr_mepc, 5'd0, 3'd2, 5'd4, op_system));
    emit(i_format(12'd4, 5'd4, 3'd0, 5'd4, op_imm));
    emit(i_format(csr_mepc, 5'd4, 3'd1, 5'd0, op_system));
    emit(mret_inst);
    add_row("ecall_mret", 2, 32'h0000_0088, 0, 4'b0, 8);  // MPIE and MIE back
  endtask

  initial begin
    rst_n     = 1'b0;
    errors    = 0;
    failed_tests = 0;
    nprog     = 0;
    nrows     = 0;
    row_begin = 0;
    last_strb = 4'b0;
    lcg_state = 32'he405_ceb6;
    for (int i = 0; i < 256; i++) begin
      dmem[i] = lcg_next();
      imem[i] = nop_inst;
    end
    build_table();
    for (int r = 0; r < nrows; r++)
      run_row(r);
    $display("%0d tests, %0d passed, %0d failed, %0d errors", nrows,
             nrows - failed_tests, failed_tests, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- list.f
rv_pkg.sv
rv_dec_if.sv
rv_decode.sv
rv_alu.sv
rv_regfile.sv
rv_csr.sv
rv_lsu.sv
rv_core.sv
tb_rv_core.sv

//--- run.sh
#!/bin/sh
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_rv_core -o sim_tb_rv_core
status=$?
if [ $status -ne 0 ]; then
  echo "Compile failed"
  exit $status
fi

./obj_dir/sim_tb_rv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit $status
fi

if grep -q "^TEST PASSED$" sim.log; then
  exit 0
fi
exit 1
